//--- files.f
logic/frame_cfg_pkg.sv
logic/frame_types_pkg.sv
logic/trigger_fanout.sv
logic/channel_framer.sv
logic/frame_merger.sv
logic/daq_top.sv
dv/tb_daq_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_daq_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)

check: run
	@if grep -q '^TESTS PASSED$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_daq_top.sv
`timescale 1ns/1ps

module tb_daq_top;
    import frame_cfg_pkg::*;
    import frame_types_pkg::*;

    localparam int N_CH       = 4;
    localparam int N_ROWS     = 9;
    localparam int LANE_MAX   = (1 << LANE_SUM_WIDTH) - 1;
    localparam int WAIT_LIMIT = 400;

    typedef struct {
        string       name;
        logic [3:0]  mask;
        int          burst;
        logic [15:0] base;
        int          max_len;
        int          exp_recs;
    } row_t;

    typedef struct {
        int                           ch;
        logic [SAMPLE_WORD_WIDTH-1:0] data;
    } sample_exp_t;

    typedef struct {
        int           ch;
        header_line_t header;
        footer_line_t footer;
    } record_exp_t;

    logic                         ACLK;
    logic                         ARESET;
    logic [SAMPLE_WORD_WIDTH-1:0] adc_samples [N_CH];
    logic [N_CH-1:0]              trig_active;
    logic                         set_config;
    logic [FRAME_LEN_WIDTH-1:0]   max_frame_len_in;
    logic [TRIG_TYPE_WIDTH-1:0]   trig_type_cfg;
    logic [TRIG_CONFIG_WIDTH-1:0] trig_config_cfg;
    logic [N_CH-1:0]              sample_valid;
    sample_out_t                  sample_data [N_CH];
    logic                         line_valid;
    frame_line_u                  line;
    logic [DROP_COUNT_WIDTH-1:0]  drop_count;

    row_t          rows [N_ROWS];
    sample_exp_t   samples_q [$];
    record_exp_t   records_q [$];
    int            sample_count [N_CH];
    int            exp_obj [N_CH];
    int            m_acc [N_CH][SAMPLES_PER_CLK];
    int            m_len [N_CH];
    int            m_frames [N_CH];
    logic [31:0]   m_ts [N_CH];
    int            rx_recs;
    int            cur_max;
    logic [3:0]    cur_type;
    logic [7:0]    cur_config;
    logic [31:0]   cyc;
    logic [31:0]   lfsr_state;
    string         cur_test;
    int            err_count;
    int            fail_count;
    logic          in_footer;
    header_line_t  held_header;

    daq_top #(
        .N_CHANNELS (N_CH),
        .QUEUE_DEPTH(4)
    ) u_daq_top (
        .ACLK            (ACLK),
        .ARESET          (ARESET),
        .adc_samples     (adc_samples),
        .trig_active     (trig_active),
        .set_config      (set_config),
        .max_frame_len_in(max_frame_len_in),
        .trig_type_cfg   (trig_type_cfg),
        .trig_config_cfg (trig_config_cfg),
        .sample_valid    (sample_valid),
        .sample_data     (sample_data),
        .line_valid      (line_valid),
        .line            (line),
        .drop_count      (drop_count)
    );

    initial ACLK = 1'b0;
    always #10 ACLK = ~ACLK;

    // mirrors the free-running timestamp for reads 2 ns after the edge
    always @(posedge ACLK) begin
        if (ARESET) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge ACLK);
        #2;
    endtask

    // build the record the framer must produce when a frame ends
    function automatic void close_frame(input int ch, input logic cont);
        record_exp_t r;
        int          charge;
        charge = 0;
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            charge += m_acc[ch][i];
            m_acc[ch][i] = 0;
        end
        r.ch                           = ch;
        r.header.line_id               = HEADER_ID;
        r.header.ch_id                 = 4'(ch);
        r.header.frame_len             = 12'(m_len[ch]);
        r.header.frame_info.reserved   = 1'b0;
        r.header.frame_info.run_state  = (m_frames[ch] == 0) ? 2'b01 : 2'b11;
        r.header.frame_info.cont       = cont;
        r.header.trig_type             = cur_type;
        r.header.timestamp             = m_ts[ch];
        r.footer.line_id               = FOOTER_ID;
        r.footer.object_id             = 16'(exp_obj[ch]);
        r.footer.charge_sum            = 24'(charge);
        r.footer.trig_config           = cur_config;
        r.footer.timestamp_low         = m_ts[ch][7:0];
        records_q.push_back(r);
        m_frames[ch]++;
        m_len[ch] = 0;
    endfunction

    task automatic match_record(input header_line_t h, input footer_line_t f);
        int idx;
        idx = -1;
        for (int i = 0; i < records_q.size(); i++) begin
            if (idx < 0 && records_q[i].ch == int'(h.ch_id)) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("unexpected record from channel %0d in test %s", h.ch_id, cur_test);
            fail_count++;
        end else begin
            check_value("header", records_q[idx].header, h);
            check_value("footer", records_q[idx].footer, f);
            records_q.delete(idx);
            rx_recs++;
        end
    endtask

    task automatic match_sample(input int ch, input logic [SAMPLE_WORD_WIDTH-1:0] data);
        int idx;
        idx = -1;
        for (int i = 0; i < samples_q.size(); i++) begin
            if (idx < 0 && samples_q[i].ch == ch) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("unexpected sample word on channel %0d in test %s", ch, cur_test);
            fail_count++;
        end else begin
            check_value($sformatf("samples_ch%0d", ch), samples_q[idx].data, data);
            samples_q.delete(idx);
        end
    endtask

    // outputs are sampled on the falling edge away from the drive point
    always @(negedge ACLK) begin
        if (ARESET) begin
            in_footer = 1'b0;
        end else begin
            for (int ch = 0; ch < N_CH; ch++) begin
                if (sample_valid[ch]) begin
                    sample_count[ch]++;
                    match_sample(ch, sample_data[ch].samples);
                end
            end
            if (in_footer) begin
                in_footer = 1'b0;
                if (!line_valid) begin
                    $display("footer line missing after header of channel %0d in test %s",
                             held_header.ch_id, cur_test);
                    fail_count++;
                end else begin
                    check_value("footer_id", 64'(FOOTER_ID), 64'(line.footer.line_id));
                    match_record(held_header, line.footer);
                end
            end else if (line_valid) begin
                check_value("header_id", 64'(HEADER_ID), 64'(line.header.line_id));
                held_header = line.header;
                in_footer   = 1'b1;
            end
        end
    end

    task automatic apply_config(input int max_len, input logic [3:0] ttype,
                                input logic [7:0] tcfg);
        set_config       = 1'b1;
        max_frame_len_in = 12'(max_len);
        trig_type_cfg    = ttype;
        trig_config_cfg  = tcfg;
        next_cycle();
        set_config = 1'b0;
        cur_max    = max_len;
        cur_type   = ttype;
        cur_config = tcfg;
        for (int ch = 0; ch < N_CH; ch++) begin
            exp_obj[ch] = 0;
        end
        repeat (3) next_cycle();
    endtask

    task automatic wait_records();
        int n;
        n = 0;
        while (records_q.size() != 0 && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (records_q.size() != 0) begin
            $display("timeout in test %s: %0d records never came out of the merger",
                     cur_test, records_q.size());
            fail_count++;
            records_q.delete();
        end
    endtask

    task automatic run_row(input row_t row, input int r);
        logic [15:0]                  s;
        logic [SAMPLE_WORD_WIDTH-1:0] word;
        sample_exp_t                  se;
        cur_test = row.name;
        if (row.max_len != 0) begin
            apply_config(row.max_len, 4'(r + 1), 8'hc0 | 8'(r));
        end
        rx_recs = 0;
        for (int ch = 0; ch < N_CH; ch++) begin
            m_len[ch]        = 0;
            m_frames[ch]     = 0;
            sample_count[ch] = 0;
            for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
                m_acc[ch][i] = 0;
            end
        end
        for (int w = 0; w < row.burst; w++) begin
            for (int ch = 0; ch < N_CH; ch++) begin
                if (row.mask[ch]) begin
                    for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
                        if (row.base == 16'hffff) begin
                            s = 16'hffff;
                        end else begin
                            s = row.base + take_bits(8);
                        end
                        word[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = s;
                        m_acc[ch][i] = m_acc[ch][i] + int'(s);
                        if (m_acc[ch][i] > LANE_MAX) begin
                            m_acc[ch][i] = LANE_MAX;
                        end
                    end
                    if (m_len[ch] == 0) begin
                        m_ts[ch] = cyc;
                    end
                    m_len[ch]++;
                    adc_samples[ch] = word;
                    se.ch   = ch;
                    se.data = word;
                    samples_q.push_back(se);
                    if (m_len[ch] == cur_max) begin
                        close_frame(ch, 1'b1);
                    end
                end
            end
            trig_active = row.mask;
            next_cycle();
        end
        trig_active = '0;
        for (int ch = 0; ch < N_CH; ch++) begin
            if (m_len[ch] != 0) begin
                close_frame(ch, 1'b0);
            end
            if (row.mask[ch]) begin
                exp_obj[ch]++;
            end
        end
        next_cycle();
        wait_records();
        // idle a little so late or extra lines still get caught
        repeat (6) next_cycle();
        check_value("record_count", 64'(row.exp_recs), 64'(rx_recs));
        for (int ch = 0; ch < N_CH; ch++) begin
            check_value($sformatf("sample_count_ch%0d", ch),
                        row.mask[ch] ? 64'(row.burst) : 64'd0, 64'(sample_count[ch]));
        end
        if (samples_q.size() != 0) begin
            $display("%0d sample words never came out in test %s", samples_q.size(), cur_test);
            fail_count++;
            samples_q.delete();
        end
        check_value("drop_count", 64'd0, 64'(drop_count));
    endtask

    initial begin
        ARESET           = 1'b1;
        trig_active      = '0;
        set_config       = 1'b0;
        max_frame_len_in = '0;
        trig_type_cfg    = '0;
        trig_config_cfg  = '0;
        for (int ch = 0; ch < N_CH; ch++) begin
            adc_samples[ch] = '0;
            exp_obj[ch]     = 0;
        end
        lfsr_state = 32'h3fc21dce;
        err_count  = 0;
        fail_count = 0;
        rx_recs    = 0;
        cur_max    = 100;
        cur_type   = '0;
        cur_config = '0;
        cur_test   = "reset";

        rows[0] = '{"single_burst",      4'b0001,  6, 16'h0100,   0, 1};
        rows[1] = '{"object_id_1",       4'b0001,  3, 16'h0020,   0, 1};
        rows[2] = '{"object_id_2",       4'b0001,  4, 16'h1000,   0, 1};
        rows[3] = '{"saturation",        4'b0010, 70, 16'hffff,   0, 1};
        rows[4] = '{"frame_split",       4'b0100, 13, 16'h0400,   5, 3};
        rows[5] = '{"object_id_restart", 4'b0001,  2, 16'h0008, 100, 1};
        rows[6] = '{"object_id_next",    4'b0001,  5, 16'h0011,   0, 1};
        rows[7] = '{"multi_merge",       4'b1111,  8, 16'h2000,   0, 4};
        rows[8] = '{"multi_split",       4'b1111,  6, 16'h0300,   4, 8};

        repeat (2) @(posedge ACLK);
        #2;
        ARESET = 1'b0;
        check_value("line_valid_after_reset", 64'd0, 64'(line_valid));
        check_value("sample_valid_after_reset", 64'd0, 64'(sample_valid));
        check_value("drop_count_after_reset", 64'd0, 64'(drop_count));
        repeat (2) next_cycle();

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(rows[r], r);
        end

        $display("errors: %0d value mismatches, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- logic/daq_top.sv
`timescale 1ns/1ps

module daq_top #(
    parameter int N_CHANNELS  = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                        ACLK,
    input  logic                                        ARESET,
    input  logic [frame_cfg_pkg::SAMPLE_WORD_WIDTH-1:0] adc_samples [N_CHANNELS],
    input  logic [N_CHANNELS-1:0]                       trig_active,
    input  logic                                        set_config,
    input  logic [frame_cfg_pkg::FRAME_LEN_WIDTH-1:0]   max_frame_len_in,
    input  logic [frame_cfg_pkg::TRIG_TYPE_WIDTH-1:0]   trig_type_cfg,
    input  logic [frame_cfg_pkg::TRIG_CONFIG_WIDTH-1:0] trig_config_cfg,
    output logic [N_CHANNELS-1:0]                       sample_valid,
    output frame_types_pkg::sample_out_t                sample_data [N_CHANNELS],
    output logic                                        line_valid,
    output frame_types_pkg::frame_line_u                line,
    output logic [frame_cfg_pkg::DROP_COUNT_WIDTH-1:0]  drop_count
);
    import frame_cfg_pkg::*;
    import frame_types_pkg::*;

    trigger_word_t              trig_word [N_CHANNELS];
    logic                       config_load;
    logic [FRAME_LEN_WIDTH-1:0] max_frame_len;
    logic [N_CHANNELS-1:0]      rec_valid;
    frame_record_t              rec [N_CHANNELS];

    trigger_fanout #(
        .N_CHANNELS(N_CHANNELS)
    ) u_trigger_fanout (
        .ACLK            (ACLK),
        .ARESET          (ARESET),
        .adc_samples     (adc_samples),
        .trig_active     (trig_active),
        .set_config      (set_config),
        .max_frame_len_in(max_frame_len_in),
        .trig_type_cfg   (trig_type_cfg),
        .trig_config_cfg (trig_config_cfg),
        .trig_word       (trig_word),
        .config_load     (config_load),
        .max_frame_len   (max_frame_len)
    );

    for (genvar g = 0; g < N_CHANNELS; g++) begin : g_framer
        channel_framer #(
            .CHANNEL_ID(g)
        ) u_channel_framer (
            .ACLK         (ACLK),
            .ARESET       (ARESET),
            .trig_word    (trig_word[g]),
            .config_load  (config_load),
            .max_frame_len(max_frame_len),
            .sample_valid (sample_valid[g]),
            .sample_data  (sample_data[g]),
            .rec_valid    (rec_valid[g]),
            .rec          (rec[g])
        );
    end

    frame_merger #(
        .N_CHANNELS (N_CHANNELS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_frame_merger (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .rec_valid (rec_valid),
        .rec       (rec),
        .line_valid(line_valid),
        .line      (line),
        .drop_count(drop_count)
    );

endmodule

//--- logic/frame_merger.sv
`timescale 1ns/1ps

module frame_merger #(
    parameter int N_CHANNELS  = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                       ACLK,
    input  logic                                       ARESET,
    input  logic [N_CHANNELS-1:0]                      rec_valid,
    input  frame_types_pkg::frame_record_t             rec [N_CHANNELS],
    output logic                                       line_valid,
    output frame_types_pkg::frame_line_u               line,
    output logic [frame_cfg_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);
    import frame_cfg_pkg::*;
    import frame_types_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CH_W  = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    frame_record_t   queue_mem [N_CHANNELS][QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr [N_CHANNELS];
    logic [PTR_W-1:0] rd_ptr [N_CHANNELS];
    logic [CNT_W-1:0] q_count [N_CHANNELS];
    logic [N_CHANNELS-1:0] push;
    logic [N_CHANNELS-1:0] pop;
    logic [N_CHANNELS-1:0] drop;
    logic [CH_W-1:0]  last_ch;
    logic [CH_W-1:0]  cur_ch;
    logic [CH_W-1:0]  pick_ch;
    logic             pick_found;
    logic             footer_phase;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // search starts one past the channel served last
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_ch    = last_ch;
        for (int off = 1; off <= N_CHANNELS; off++) begin
            idx = (int'(last_ch) + off) % N_CHANNELS;
            if (!pick_found && q_count[idx] != '0) begin
                pick_found = 1'b1;
                pick_ch    = CH_W'(idx);
            end
        end
    end

    always_comb begin
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            drop[ch] = rec_valid[ch] && (q_count[ch] == CNT_W'(QUEUE_DEPTH));
            push[ch] = rec_valid[ch] && !drop[ch];
            pop[ch]  = footer_phase && (cur_ch == CH_W'(ch));
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            footer_phase <= 1'b0;
            line_valid   <= 1'b0;
            last_ch      <= CH_W'(N_CHANNELS - 1);
            cur_ch       <= '0;
            drop_count   <= '0;
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                wr_ptr[ch]  <= '0;
                rd_ptr[ch]  <= '0;
                q_count[ch] <= '0;
            end
        end else begin
            drop_count <= drop_count + DROP_COUNT_WIDTH'($countones(drop));
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                if (push[ch]) begin
                    wr_ptr[ch] <= ptr_inc(wr_ptr[ch]);
                end
                if (pop[ch]) begin
                    rd_ptr[ch] <= ptr_inc(rd_ptr[ch]);
                end
                q_count[ch] <= q_count[ch] + CNT_W'(push[ch]) - CNT_W'(pop[ch]);
            end
            if (footer_phase) begin
                footer_phase <= 1'b0;
                line_valid   <= 1'b1;
            end else if (pick_found) begin
                footer_phase <= 1'b1;
                line_valid   <= 1'b1;
                cur_ch       <= pick_ch;
                last_ch      <= pick_ch;
            end else begin
                line_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            if (push[ch]) begin
                queue_mem[ch][wr_ptr[ch]] <= rec[ch];
            end
        end
        if (footer_phase) begin
            line.footer <= queue_mem[cur_ch][rd_ptr[cur_ch]].footer;
        end else if (pick_found) begin
            line.header <= queue_mem[pick_ch][rd_ptr[pick_ch]].header;
        end
    end

    // footer_phase high means the line on the output is a header
    a_line_pair: assert property (@(posedge ACLK) disable iff (ARESET)
        line_valid && footer_phase |-> line.header.line_id == HEADER_ID
        ##1 line_valid && line.footer.line_id == FOOTER_ID);

endmodule

//--- logic/channel_framer.sv
`timescale 1ns/1ps

module channel_framer #(
    parameter int CHANNEL_ID = 0
) (
    input  logic                                      ACLK,
    input  logic                                      ARESET,
    input  frame_types_pkg::trigger_word_t            trig_word,
    input  logic                                      config_load,
    input  logic [frame_cfg_pkg::FRAME_LEN_WIDTH-1:0] max_frame_len,
    output logic                                      sample_valid,
    output frame_types_pkg::sample_out_t              sample_data,
    output logic                                      rec_valid,
    output frame_types_pkg::frame_record_t            rec
);
    import frame_cfg_pkg::*;
    import frame_types_pkg::*;

    typedef logic [SAMPLES_PER_CLK-1:0][LANE_SUM_WIDTH-1:0] lane_sums_t;

    logic                         prev_active;
    logic [FRAME_LEN_WIDTH-1:0]   frame_len;
    lane_sums_t                   lane_sum;
    logic [1:0]                   run_state;
    logic [OBJECT_ID_WIDTH-1:0]   object_id;
    logic [TIMESTAMP_WIDTH-1:0]   frame_ts;
    logic [TRIG_TYPE_WIDTH-1:0]   frame_type;
    logic [TRIG_CONFIG_WIDTH-1:0] frame_config;

    logic                         rising;
    logic                         falling;
    logic                         start;
    logic                         split;
    logic                         rec_fire;
    logic [FRAME_LEN_WIDTH-1:0]   next_len;
    lane_sums_t                   next_sum;
    lane_sums_t                   rec_sum;
    logic [CHARGE_SUM_WIDTH-1:0]  charge_sum;
    logic [OBJECT_ID_WIDTH-1:0]   obj_base;
    logic [OBJECT_ID_WIDTH-1:0]   obj_next;
    logic [TIMESTAMP_WIDTH-1:0]   eff_ts;
    logic [1:0]                   eff_run;
    frame_record_t                rec_next;

    // clamp at the top of the lane range
    function automatic logic [LANE_SUM_WIDTH-1:0] sat_add(
        input logic [LANE_SUM_WIDTH-1:0] acc,
        input logic [SAMPLE_WIDTH-1:0]   sample
    );
        logic [LANE_SUM_WIDTH:0] sum;
        sum = {1'b0, acc} + (LANE_SUM_WIDTH + 1)'(sample);
        if (sum[LANE_SUM_WIDTH]) begin
            return '1;
        end
        return sum[LANE_SUM_WIDTH-1:0];
    endfunction

    assign rising  = trig_word.active & ~prev_active;
    assign falling = ~trig_word.active & prev_active & (frame_len != '0);
    // a frame also starts on the word after a split
    assign start   = trig_word.active & (rising | (frame_len == '0));

    assign next_len = start ? FRAME_LEN_WIDTH'(1) : frame_len + 1'b1;
    assign split    = trig_word.active & (next_len >= max_frame_len);
    assign rec_fire = split | falling;

    always_comb begin
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            next_sum[i] = sat_add(start ? '0 : lane_sum[i],
                                  trig_word.samples[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
        end
        rec_sum    = split ? next_sum : lane_sum;
        charge_sum = '0;
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            charge_sum = charge_sum + CHARGE_SUM_WIDTH'(rec_sum[i]);
        end
    end

    assign obj_base = config_load ? '1 : object_id;
    assign obj_next = rising ? obj_base + 1'b1 : obj_base;
    assign eff_ts   = start ? trig_word.timestamp : frame_ts;
    assign eff_run  = rising ? 2'b01 : run_state;

    always_comb begin
        rec_next.header.line_id              = HEADER_ID;
        rec_next.header.ch_id                = CH_ID_WIDTH'(CHANNEL_ID);
        rec_next.header.frame_len            = split ? next_len : frame_len;
        rec_next.header.frame_info.reserved  = 1'b0;
        rec_next.header.frame_info.run_state = eff_run;
        rec_next.header.frame_info.cont      = split;
        rec_next.header.trig_type            = start ? trig_word.trig_type : frame_type;
        rec_next.header.timestamp            = eff_ts;
        rec_next.footer.line_id              = FOOTER_ID;
        rec_next.footer.object_id            = rising ? obj_next : object_id;
        rec_next.footer.charge_sum           = charge_sum;
        rec_next.footer.trig_config          = start ? trig_word.trig_config : frame_config;
        rec_next.footer.timestamp_low        = eff_ts[TS_LOW_WIDTH-1:0];
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            prev_active  <= 1'b0;
            frame_len    <= '0;
            run_state    <= 2'b00;
            object_id    <= '1;
            sample_valid <= 1'b0;
            rec_valid    <= 1'b0;
        end else begin
            prev_active  <= trig_word.active;
            sample_valid <= trig_word.active;
            rec_valid    <= rec_fire;
            object_id    <= obj_next;
            if (split) begin
                frame_len <= '0;
                run_state <= 2'b11;
            end else if (trig_word.active) begin
                frame_len <= next_len;
                run_state <= eff_run;
            end else begin
                frame_len <= '0;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        sample_data.samples <= trig_word.samples;
        if (trig_word.active) begin
            lane_sum <= next_sum;
        end
        if (start) begin
            frame_ts     <= trig_word.timestamp;
            frame_type   <= trig_word.trig_type;
            frame_config <= trig_word.trig_config;
        end
        if (rec_fire) begin
            rec <= rec_next;
        end
    end

    // a one-word frame limit would legally fire every cycle
    a_rec_gap: assert property (@(posedge ACLK) disable iff (ARESET)
        rec_valid && max_frame_len > 1 |=> !rec_valid);

    a_len_bound: assert property (@(posedge ACLK) disable iff (ARESET)
        rec_valid |-> rec.header.frame_len != '0 && rec.header.frame_len <= max_frame_len);

endmodule

//--- logic/trigger_fanout.sv
`timescale 1ns/1ps

module trigger_fanout #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                          ACLK,
    input  logic                                          ARESET,
    input  logic [frame_cfg_pkg::SAMPLE_WORD_WIDTH-1:0]   adc_samples [N_CHANNELS],
    input  logic [N_CHANNELS-1:0]                         trig_active,
    input  logic                                          set_config,
    input  logic [frame_cfg_pkg::FRAME_LEN_WIDTH-1:0]     max_frame_len_in,
    input  logic [frame_cfg_pkg::TRIG_TYPE_WIDTH-1:0]     trig_type_cfg,
    input  logic [frame_cfg_pkg::TRIG_CONFIG_WIDTH-1:0]   trig_config_cfg,
    output frame_types_pkg::trigger_word_t                trig_word [N_CHANNELS],
    output logic                                          config_load,
    output logic [frame_cfg_pkg::FRAME_LEN_WIDTH-1:0]     max_frame_len
);
    import frame_cfg_pkg::*;

    logic [TIMESTAMP_WIDTH-1:0]   timestamp;
    logic [TRIG_TYPE_WIDTH-1:0]   trig_type_q;
    logic [TRIG_CONFIG_WIDTH-1:0] trig_config_q;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            timestamp     <= '0;
            max_frame_len <= DEFAULT_MAX_FRAME_LEN;
            trig_type_q   <= '0;
            trig_config_q <= '0;
            config_load   <= 1'b0;
        end else begin
            timestamp   <= timestamp + 1'b1;
            config_load <= set_config;
            if (set_config) begin
                max_frame_len <= max_frame_len_in;
                trig_type_q   <= trig_type_cfg;
                trig_config_q <= trig_config_cfg;
            end
        end
    end

    // every channel sees the same stamp in a given cycle
    always_ff @(posedge ACLK) begin
        for (int ch = 0; ch < N_CHANNELS; ch++) begin
            if (ARESET) begin
                trig_word[ch].active <= 1'b0;
            end else begin
                trig_word[ch].active      <= trig_active[ch];
                trig_word[ch].samples     <= adc_samples[ch];
                trig_word[ch].timestamp   <= timestamp;
                trig_word[ch].trig_type   <= trig_type_q;
                trig_word[ch].trig_config <= trig_config_q;
            end
        end
    end

    a_no_zero_len: assert property (@(posedge ACLK) disable iff (ARESET)
        set_config |-> max_frame_len_in != '0);

endmodule

//--- logic/frame_types_pkg.sv
package frame_types_pkg;
    import frame_cfg_pkg::*;

    typedef struct packed {
        logic                         active;
        logic [SAMPLE_WORD_WIDTH-1:0] samples;
        logic [TIMESTAMP_WIDTH-1:0]   timestamp;
        logic [TRIG_TYPE_WIDTH-1:0]   trig_type;
        logic [TRIG_CONFIG_WIDTH-1:0] trig_config;
    } trigger_word_t;

    typedef struct packed {
        logic [SAMPLE_WORD_WIDTH-1:0] samples;
    } sample_out_t;

    // run_state 01 first frame of a trigger, 11 continued frame
    typedef struct packed {
        logic       reserved;
        logic [1:0] run_state;
        logic       cont;
    } frame_info_t;

    typedef struct packed {
        logic [LINE_ID_WIDTH-1:0]   line_id;
        logic [CH_ID_WIDTH-1:0]     ch_id;
        logic [FRAME_LEN_WIDTH-1:0] frame_len;
        frame_info_t                frame_info;
        logic [TRIG_TYPE_WIDTH-1:0] trig_type;
        logic [TIMESTAMP_WIDTH-1:0] timestamp;
    } header_line_t;

    typedef struct packed {
        logic [LINE_ID_WIDTH-1:0]     line_id;
        logic [OBJECT_ID_WIDTH-1:0]   object_id;
        logic [CHARGE_SUM_WIDTH-1:0]  charge_sum;
        logic [TRIG_CONFIG_WIDTH-1:0] trig_config;
        logic [TS_LOW_WIDTH-1:0]      timestamp_low;
    } footer_line_t;

    // line_id picks the view
    typedef union packed {
        header_line_t header;
        footer_line_t footer;
    } frame_line_u;

    typedef struct packed {
        header_line_t header;
        footer_line_t footer;
    } frame_record_t;

endpackage

//--- logic/frame_cfg_pkg.sv
package frame_cfg_pkg;

    // one ADC word carries four samples
    localparam int SAMPLE_WIDTH      = 16;
    localparam int SAMPLES_PER_CLK   = 4;
    localparam int SAMPLE_WORD_WIDTH = SAMPLE_WIDTH * SAMPLES_PER_CLK;

    localparam int LINE_WIDTH        = 64;
    localparam int LANE_SUM_WIDTH    = 22;
    localparam int CHARGE_SUM_WIDTH  = 24;
    localparam int FRAME_LEN_WIDTH   = 12;
    localparam int OBJECT_ID_WIDTH   = 16;
    localparam int TIMESTAMP_WIDTH   = 32;
    localparam int TS_LOW_WIDTH      = 8;
    localparam int CH_ID_WIDTH       = 4;
    localparam int LINE_ID_WIDTH     = 8;
    localparam int TRIG_TYPE_WIDTH   = 4;
    localparam int TRIG_CONFIG_WIDTH = 8;
    localparam int DROP_COUNT_WIDTH  = 16;

    // line tags
    localparam logic [LINE_ID_WIDTH-1:0] HEADER_ID = 8'hA5;
    localparam logic [LINE_ID_WIDTH-1:0] FOOTER_ID = 8'h5A;

    localparam logic [FRAME_LEN_WIDTH-1:0] DEFAULT_MAX_FRAME_LEN = 12'd100;

endpackage
